/* tileLayerGen.f */
+incdir+verilog
verilog/tileLayerPkg.sv
verilog/tileLayerIf.sv
verilog/videoTiming.sv
verilog/ctrlRegs.sv
verilog/vramSequencer.sv
verilog/tileLayerGen.sv
testbench/tileLayerGen_assert.sv
testbench/tileLayerGenChecker.sv
testbench/tileLayerGenTb.sv

/* Makefile */
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing --assert --top-module tileLayerGenTb \
		-f tileLayerGen.f -Mdir obj_dir -o tileLayerGenSim
	./obj_dir/tileLayerGenSim | tee sim.log
	@grep -q "^TEST PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

/* testbench/tileLayerGenTb.sv */
// Testbench for the tile layer generator with APB stimulus and an 8K VRAM model
`timescale 1ns/10ps
`include "tileLayerGen_settings.svh"

module tileLayerGenTb;

    localparam int LINE_CYCLES    = `TL_H_TOTAL * 4;
    localparam int TIMEOUT_CYCLES = LINE_CYCLES * `TL_V_TOTAL * 13 / 10;  // 1.3 frames

    logic                  M24 = 1'b0;
    logic                  rstN;
    logic                  psel, penable, pwrite, pready, pslverr;
    logic [`TL_ADDR_W-1:0] paddr, vramAddr;
    logic [7:0]            pwdata, prdata, vramWData, vramRData;
    logic                  vramCsN, vramOeN, vramWeN;
    logic                  m12, pe, pq, hvot, irqN, firqN, nmiN;
    logic [7:0]            vramMem [0:(1 << `TL_ADDR_W) - 1];
    logic [`TL_ADDR_W-1:0] addrList [16];   // Random VRAM addresses
    logic [31:0]           seed = 32'h5f789c76;
    int                    errCount;
    int                    checkCount;
    int                    cycles = 0;
    int                    lastErr = 0;
    int                    testNum = 0;
    int                    i;

    tileLayerGen u_tileLayerGen (.*);
    tileLayerGenChecker u_checker (.*);

    always #10 M24 = ~M24;                  // 20 ns period

    // VRAM model, read data follows the address
    assign vramRData = vramMem[vramAddr];
    always @(posedge M24) begin
        if (!vramCsN && !vramWeN) begin
            vramMem[vramAddr] <= vramWData;
        end
    end

    always @(posedge M24) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Run stopped after %0d cycles, an awaited response never came", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // One APB transfer, held until pready
    task automatic apbAccess(input logic wr, input logic [`TL_ADDR_W-1:0] addr,
            input logic [7:0] data);
        @(negedge M24);
        psel   = 1'b1;
        pwrite = wr;
        paddr  = addr;
        pwdata = data;
        @(negedge M24);
        penable = 1'b1;
        @(posedge M24);
        while (!pready) @(posedge M24);
        @(negedge M24);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic reportTest(input string name);
        testNum++;
        $display("Test %0d %s: %0d errors", testNum, name, errCount - lastErr);
        lastErr = errCount;
    endtask

    initial begin
        for (i = 0; i < (1 << `TL_ADDR_W); i++) begin
            vramMem[i] = 8'(i ^ (i >> 5));  // Fill from the whole address
        end
        rstN    = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        repeat (8) @(negedge M24);
        rstN = 1'b1;

        repeat (2 * LINE_CYCLES) @(negedge M24);    // Flip 0 render slots
        reportTest("clocks, beam and render slots");
        apbAccess(1'b1, `TL_REG_FLIP, 8'h01);
        repeat (2 * LINE_CYCLES) @(negedge M24);
        reportTest("render slots with flip");

        apbAccess(1'b1, `TL_REG_INT, 8'hFA);        // Upper bits dropped
        apbAccess(1'b1, `TL_REG_FLIP, 8'hFF);
        apbAccess(1'b0, `TL_REG_INT, 8'h00);
        apbAccess(1'b0, `TL_REG_FLIP, 8'h00);
        apbAccess(1'b1, 13'h1C40, 8'hFF);           // Unmapped offset
        apbAccess(1'b0, 13'h1C40, 8'h00);
        apbAccess(1'b0, `TL_REG_INT, 8'h00);
        apbAccess(1'b0, `TL_REG_FLIP, 8'h00);
        reportTest("control registers");

        for (i = 0; i < 16; i++) begin
            seed        = lcgNext(seed);
            addrList[i] = seed[28:16] % 13'h1C00;   // Below the register window
            apbAccess(1'b1, addrList[i], seed[7:0]);
        end
        for (i = 0; i < 16; i++) begin
            apbAccess(1'b0, addrList[i], 8'h00);
        end
        reportTest("VRAM writes and reads");

        apbAccess(1'b1, `TL_REG_INT, 8'h07);
        while (firqN) @(negedge M24);
        while (nmiN) @(negedge M24);
        while (irqN) @(negedge M24);                // Blanking entry
        apbAccess(1'b1, `TL_REG_INT, 8'h05);        // FIRQ off
        repeat (3 * LINE_CYCLES) @(negedge M24);
        reportTest("interrupts");

        $display("Tests: %0d, checks: %0d, errors: %0d, assertion failures: %0d",
            testNum, checkCount, errCount, u_tileLayerGen.u_assert.failures);
        if (errCount == 0 && u_tileLayerGen.u_assert.failures == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* testbench/tileLayerGenChecker.sv */
// Checker with beam model, VRAM reference function and APB and interrupt comparison
`timescale 1ns/10ps
`include "tileLayerGen_settings.svh"

module tileLayerGenChecker (
    input  logic                  M24,
    input  logic                  rstN,
    input  logic                  psel, penable, pwrite, pready, pslverr,
    input  logic [`TL_ADDR_W-1:0] paddr, vramAddr,
    input  logic [7:0]            pwdata, prdata, vramWData,
    input  logic                  vramCsN, vramOeN, vramWeN,
    input  logic                  m12, pe, pq, hvot, irqN, firqN, nmiN,
    output int                    errCount,     // Mismatches so far
    output int                    checkCount    // Compares done
);

    int                   n;                    // Edges since reset
    int                   pixel;
    int                   line;
    int                   waits;                // Access cycles before pready
    int                   errors = 0;
    int                   checks = 0;
    tileLayerPkg::slotT   slot;
    logic                 lineStart;
    logic                 flipM;                // Flip as written over APB
    tileLayerPkg::intVecT enM;
    tileLayerPkg::intVecT flagM;
    tileLayerPkg::intVecT trigM;
    logic [15:0]          expVram;              // csN, oeN, weN, address
    logic                 expValid;
    logic                 regWin;
    logic [7:0]           shadow [int];         // VRAM bytes written over APB

    assign errCount   = errors;
    assign checkCount = checks;
    assign slot       = tileLayerPkg::slotT'(n % 4);
    assign pixel      = (n / 4) % `TL_H_TOTAL;
    assign line       = (n / 4 / `TL_H_TOTAL) % `TL_V_TOTAL;
    assign lineStart  = slot == 2'd0 && pixel == 0;
    assign trigM      = {lineStart && line == `TL_VBLANK_LINE,
                         lineStart && line[0] == 1'b0,
                         lineStart && line % `TL_NMI_LINES == 0};
    assign regWin     = paddr[12:10] == 3'b111;

    //--------------------------------------------------------------------------
    // Expected VRAM bus one edge after a state
    //--------------------------------------------------------------------------
    function automatic logic [15:0] refVram(input tileLayerPkg::slotT s, input int h,
            input int v, input logic f, input logic req, input logic wr,
            input logic [`TL_ADDR_W-1:0] a);
        logic [4:0] row;
        logic [5:0] col;
        logic [7:0] scrollLine;
        row        = v[7:3] ^ {5{f}};
        col        = h[8:3] ^ {6{f}};
        scrollLine = v[7:0] ^ {8{f}};
        case (s)
            `TL_SLOT_MAP_A, `TL_SLOT_MAP_B: refVram = {3'b001, 1'b0, s[0], row, col};
            `TL_SLOT_CPU: refVram = req ? {1'b0, wr, !wr, a} : 16'hE000;  // Idle slot
            default: refVram = {3'b001, `TL_SCROLL_PAGE, 1'b0, scrollLine};
        endcase
    endfunction

    task automatic compareValue(input string name, input logic [31:0] got,
            input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    //--------------------------------------------------------------------------
    // Compare on every edge, old values seen before the update
    //--------------------------------------------------------------------------
    always @(posedge M24) begin
        if (!rstN) begin
            n        <= 0;
            waits    <= 0;
            flipM    <= 1'b0;
            enM      <= '0;
            flagM    <= '0;
            expValid <= 1'b0;
        end else begin
            compareValue("m12", 32'(m12), 32'(slot[0]));
            compareValue("pe", 32'(pe), 32'(slot[1]));
            compareValue("pq", 32'(pq), 32'(slot[0] ^ slot[1]));
            compareValue("hvot", 32'(hvot), 32'(line >= `TL_VBLANK_LINE));
            compareValue("irqN/firqN/nmiN", 32'({irqN, firqN, nmiN}), 32'(flagM ^ 3'b111));
            if (expValid) begin
                compareValue("vramAddr", 32'(vramAddr), 32'(expVram[12:0]));
                compareValue("vramCsN/OeN/WeN", 32'({vramCsN, vramOeN, vramWeN}),
                    32'(expVram[15:13]));
            end
            if (psel && penable) begin
                waits <= waits + 1;
            end
            if (psel && penable && pready) begin
                waits <= 0;
                if (regWin) begin
                    if (waits != 0) begin
                        errors++;
                        $display("Register access to %h waited %0d cycles, expected none",
                            paddr, waits);
                    end
                    compareValue("pslverr", 32'(pslverr),
                        32'(paddr != `TL_REG_INT && paddr != `TL_REG_FLIP));
                    if (!pwrite && paddr == `TL_REG_INT) begin
                        compareValue("prdata", 32'(prdata), 32'({5'b0, enM}));
                    end
                    if (!pwrite && paddr == `TL_REG_FLIP) begin
                        compareValue("prdata", 32'(prdata), 32'({7'b0, flipM}));
                    end
                    if (pwrite && paddr == `TL_REG_INT) begin
                        enM <= pwdata[2:0];
                    end
                    if (pwrite && paddr == `TL_REG_FLIP) begin
                        flipM <= pwdata[0];
                    end
                end else begin
                    compareValue("vramAddr", 32'(vramAddr), 32'(paddr));  // Granted cycle
                    compareValue("pslverr", 32'(pslverr), 32'(1'b0));
                    if (waits < 1 || waits > 4) begin
                        errors++;
                        $display("VRAM access to %h waited %0d cycles, not 1 to 4",
                            paddr, waits);
                    end
                    if (pwrite) begin
                        compareValue("vramWData", 32'(vramWData), 32'(pwdata));
                        shadow[int'(paddr)] = pwdata;
                    end else if (shadow.exists(int'(paddr))) begin
                        compareValue("prdata", 32'(prdata), 32'(shadow[int'(paddr)]));
                    end
                end
            end
            expVram  <= refVram(slot, pixel, line, flipM, psel && penable && !regWin,
                pwrite, paddr);
            expValid <= 1'b1;
            flagM    <= enM & (flagM | trigM);      // Set by beam event, masked by enable
            n        <= n + 1;
        end
    end

endmodule

/* testbench/tileLayerGen_assert.sv */
// Protocol assertions on APB handshake, VRAM strobes and masked interrupt outputs
`timescale 1ns/10ps

module tileLayerGenAssert (
    input logic                 M24,
    input logic                 rstN,
    input logic                 psel,
    input logic                 penable,
    input logic                 pready,
    input logic                 vramCsN,
    input logic                 vramOeN,
    input logic                 vramWeN,
    input logic                 irqN,
    input logic                 firqN,
    input logic                 nmiN,
    input tileLayerPkg::intVecT intEn       // Enables inside the register block
);

    int failures = 0;                       // Failed assertions so far

    apbReady: assert property (@(posedge M24) disable iff (!rstN)
        pready |-> psel && penable) else begin
        $error("pready outside an access phase");
        failures++;
    end
    weNeedsCs: assert property (@(posedge M24) disable iff (!rstN)
        !vramWeN |-> !vramCsN) else begin
        $error("VRAM write strobe without chip select");
        failures++;
    end
    oeWeApart: assert property (@(posedge M24) disable iff (!rstN)
        !(!vramOeN && !vramWeN)) else begin
        $error("VRAM read and write strobes both low");
        failures++;
    end

    // Flag clears one edge after its enable drops
    irqMasked: assert property (@(posedge M24) disable iff (!rstN)
        !intEn.irq |=> irqN) else begin
        $error("irqN low with its enable off");
        failures++;
    end
    firqMasked: assert property (@(posedge M24) disable iff (!rstN)
        !intEn.firq |=> firqN) else begin
        $error("firqN low with its enable off");
        failures++;
    end
    nmiMasked: assert property (@(posedge M24) disable iff (!rstN)
        !intEn.nmi |=> nmiN) else begin
        $error("nmiN low with its enable off");
        failures++;
    end

endmodule

bind tileLayerGen tileLayerGenAssert u_assert (
    .M24     (M24),
    .rstN    (rstN),
    .psel    (psel),
    .penable (penable),
    .pready  (pready),
    .vramCsN (vramCsN),
    .vramOeN (vramOeN),
    .vramWeN (vramWeN),
    .irqN    (irqN),
    .firqN   (firqN),
    .nmiN    (nmiN),
    .intEn   (u_ctrlRegs.intEn)
);

/* verilog/tileLayerGen.sv */
// Tile layer generator top joining video timing, control registers and VRAM sequencer
`timescale 1ns/10ps
`include "tileLayerGen_settings.svh"

module tileLayerGen (
    input  logic                  M24,          // Master clock
    input  logic                  rstN,         // Sync reset
    // APB slave
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [`TL_ADDR_W-1:0] paddr,
    input  logic [7:0]            pwdata,
    output logic [7:0]            prdata,
    output logic                  pready,
    output logic                  pslverr,
    // VRAM
    output logic [`TL_ADDR_W-1:0] vramAddr,
    output logic                  vramCsN,
    output logic                  vramOeN,
    output logic                  vramWeN,
    output logic [7:0]            vramWData,
    input  logic [7:0]            vramRData,
    // Video and interrupts
    output logic                  m12,
    output logic                  pe,
    output logic                  pq,
    output logic                  hvot,
    output logic                  irqN,
    output logic                  firqN,
    output logic                  nmiN
);

    beamIf    beam ();                          // Timing to consumers
    cpuVramIf cpuVram ();                       // Registers to sequencer
    logic     flip;

    videoTiming u_videoTiming (
        .M24  (M24),
        .rstN (rstN),
        .beam (beam.timing),
        .m12  (m12),
        .pe   (pe),
        .pq   (pq),
        .hvot (hvot)
    );

    ctrlRegs u_ctrlRegs (
        .M24     (M24),
        .rstN    (rstN),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .beam    (beam.regs),
        .cpu     (cpuVram.regs),
        .flip    (flip),
        .irqN    (irqN),
        .firqN   (firqN),
        .nmiN    (nmiN)
    );

    vramSequencer u_vramSequencer (
        .M24       (M24),
        .rstN      (rstN),
        .beam      (beam.seq),
        .cpu       (cpuVram.seq),
        .flip      (flip),
        .vramAddr  (vramAddr),                  // Union to flat bus
        .vramCsN   (vramCsN),
        .vramOeN   (vramOeN),
        .vramWeN   (vramWeN),
        .vramWData (vramWData),
        .vramRData (vramRData)
    );

endmodule

/* verilog/vramSequencer.sv */
// VRAM slot sequencer for map and scroll fetches and the CPU access slot
`timescale 1ns/10ps
`include "tileLayerGen_settings.svh"

module vramSequencer (
    input  logic                   M24,         // Master clock
    input  logic                   rstN,        // Sync reset
    beamIf.seq                     beam,        // Slot and beam counts
    cpuVramIf.seq                  cpu,         // CPU request
    input  logic                   flip,        // Flip screen
    output tileLayerPkg::vramAddrU vramAddr,
    output logic                   vramCsN,
    output logic                   vramOeN,
    output logic                   vramWeN,
    output logic [7:0]             vramWData,
    input  logic [7:0]             vramRData
);

    tileLayerPkg::vramAddrU nextAddr;
    logic                   nextCsN;
    logic                   nextOeN;
    logic                   nextWeN;
    logic                   nextGrant;
    logic                   cpuWrite;           // CPU write in this slot

    //--------------------------------------------------------------------------
    // Slot owner and address build
    //--------------------------------------------------------------------------
    always_comb begin
        nextAddr  = '0;
        nextCsN   = 1'b1;
        nextOeN   = 1'b1;
        nextWeN   = 1'b1;
        nextGrant = 1'b0;
        case (beam.slot)
            `TL_SLOT_MAP_A, `TL_SLOT_MAP_B: begin
                nextAddr.map.layer  = beam.slot;                    // Layer 0 or 1
                nextAddr.map.row    = beam.vCount[7:3] ^ {5{flip}};
                nextAddr.map.column = beam.hCount[8:3] ^ {6{flip}};
                nextCsN             = 1'b0;
                nextOeN             = 1'b0;
            end
            `TL_SLOT_CPU: begin
                if (cpu.req) begin
                    nextAddr  = cpu.addr;
                    nextCsN   = 1'b0;
                    nextOeN   = cpu.write;        // Read strobe
                    nextWeN   = !cpu.write;       // Write strobe
                    nextGrant = 1'b1;
                end
            end
            default: begin
                nextAddr.scroll.page  = `TL_SCROLL_PAGE;
                nextAddr.scroll.spare = 1'b0;
                nextAddr.scroll.line  = beam.vCount[7:0] ^ {8{flip}};
                nextCsN               = 1'b0;
                nextOeN               = 1'b0;
            end
        endcase
    end

    assign cpuWrite = nextGrant && cpu.write;

    //--------------------------------------------------------------------------
    // Registered VRAM outputs
    //--------------------------------------------------------------------------
    always_ff @(posedge M24) begin
        vramAddr <= nextAddr;
        if (cpuWrite) begin
            vramWData <= cpu.wdata;                 // Held between writes
        end
    end

    always_ff @(posedge M24) begin
        if (!rstN) begin
            vramCsN   <= 1'b1;
            vramOeN   <= 1'b1;
            vramWeN   <= 1'b1;
            cpu.grant <= 1'b0;
        end else begin
            vramCsN   <= nextCsN;
            vramOeN   <= nextOeN;
            vramWeN   <= nextWeN;
            cpu.grant <= nextGrant;                 // With the CPU output cycle
        end
    end

    assign cpu.rdata = vramRData;                   // Valid while granted

endmodule

/* verilog/ctrlRegs.sv */
// Control registers behind APB with interrupt flags and VRAM request forwarding
`timescale 1ns/10ps
`include "tileLayerGen_settings.svh"

module ctrlRegs (
    input  logic                  M24,      // Master clock
    input  logic                  rstN,     // Sync reset
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [`TL_ADDR_W-1:0] paddr,
    input  logic [7:0]            pwdata,
    output logic [7:0]            prdata,
    output logic                  pready,
    output logic                  pslverr,
    beamIf.regs                   beam,     // Trigger pulses
    cpuVramIf.regs                cpu,      // VRAM slot request
    output logic                  flip,     // Flip screen
    output logic                  irqN,
    output logic                  firqN,
    output logic                  nmiN
);

    tileLayerPkg::intVecT intEn;            // Enables at 0x1D00
    tileLayerPkg::intVecT intFlag;          // Pending interrupts
    tileLayerPkg::intVecT trig;
    logic                 accessPhase;
    logic                 regWin;           // 0x1C00..0x1FFF
    logic                 hitInt;
    logic                 hitFlip;
    logic                 regWrite;

    //--------------------------------------------------------------------------
    // APB decode
    //--------------------------------------------------------------------------
    assign accessPhase = psel && penable;
    assign regWin      = (paddr & `TL_REG_WINDOW) == `TL_REG_WINDOW;
    assign hitInt      = paddr == `TL_REG_INT;
    assign hitFlip     = paddr == `TL_REG_FLIP;
    assign regWrite    = accessPhase && pwrite && regWin;

    // Registers answer at once, VRAM waits for its slot
    assign pready  = accessPhase && (regWin || cpu.grant);
    assign pslverr = accessPhase && regWin && !(hitInt || hitFlip);  // Unmapped offset

    always_comb begin
        prdata = '0;
        if (regWin) begin
            if (hitInt) begin
                prdata = {5'b0, intEn};
            end else if (hitFlip) begin
                prdata = {7'b0, flip};
            end
        end else begin
            prdata = cpu.rdata;             // VRAM read data
        end
    end

    // Pending VRAM access, held by APB until grant
    assign cpu.req   = accessPhase && !regWin;
    assign cpu.write = pwrite;
    assign cpu.addr  = paddr;
    assign cpu.wdata = pwdata;

    //--------------------------------------------------------------------------
    // Control registers
    //--------------------------------------------------------------------------
    always_ff @(posedge M24) begin
        if (!rstN) begin
            intEn <= '0;
            flip  <= 1'b0;
        end else if (regWrite) begin
            if (hitInt) begin
                intEn <= pwdata[2:0];       // irq, firq, nmi enables
            end
            if (hitFlip) begin
                flip <= pwdata[0];
            end
        end
    end

    //--------------------------------------------------------------------------
    // Interrupt flags
    //--------------------------------------------------------------------------
    assign trig.irq  = beam.irqTrig;
    assign trig.firq = beam.firqTrig;
    assign trig.nmi  = beam.nmiTrig;

    always_ff @(posedge M24) begin
        if (!rstN) begin
            intFlag <= '0;
        end else begin
            intFlag <= intEn & (intFlag | trig);    // Cleared by enable low
        end
    end

    assign irqN  = ~intFlag.irq;            // Active low outputs
    assign firqN = ~intFlag.firq;
    assign nmiN  = ~intFlag.nmi;

endmodule

/* verilog/videoTiming.sv */
// Video timing for slot phases, CPU clocks, beam counters, blanking and beam events
`timescale 1ns/10ps
`include "tileLayerGen_settings.svh"

module videoTiming (
    input  logic  M24,              // Master clock
    input  logic  rstN,             // Sync reset
    beamIf.timing beam,             // Beam state out
    output logic  m12,              // CPU main clock
    output logic  pe,               // E clock
    output logic  pq,               // Q clock, 90 degrees ahead
    output logic  hvot              // Vertical blanking
);

    tileLayerPkg::slotT   slot;     // Phase counter
    tileLayerPkg::hCountT hCount;
    tileLayerPkg::vCountT vCount;
    logic                 pixelEnd; // Last slot of pixel
    logic                 lineEnd;  // Last slot of line
    logic                 frameEnd; // Last slot of frame
    logic                 lineStart;

    //--------------------------------------------------------------------------
    // Slot, pixel and line counters
    //--------------------------------------------------------------------------
    assign pixelEnd = &slot;
    assign lineEnd  = pixelEnd && (hCount == tileLayerPkg::hCountT'(`TL_H_TOTAL - 1));
    assign frameEnd = lineEnd && (vCount == tileLayerPkg::vCountT'(`TL_V_TOTAL - 1));

    always_ff @(posedge M24) begin
        if (!rstN) begin
            slot   <= '0;
            hCount <= '0;
            vCount <= '0;
        end else begin
            slot <= slot + 2'd1;            // Wraps every pixel
            if (lineEnd) begin
                hCount <= '0;
            end else if (pixelEnd) begin
                hCount <= hCount + 9'd1;
            end
            if (frameEnd) begin
                vCount <= '0;               // Back to top line
            end else if (lineEnd) begin
                vCount <= vCount + 9'd1;
            end
        end
    end

    //--------------------------------------------------------------------------
    // CPU clocks and blanking
    //--------------------------------------------------------------------------
    assign m12  = slot[0];                  // Half master rate
    assign pe   = slot[1];                  // High in slots 2 and 3
    assign pq   = slot[1] ^ slot[0];        // High in slots 1 and 2
    assign hvot = vCount >= tileLayerPkg::vCountT'(`TL_VBLANK_LINE);

    // Beam events, one cycle at each line start
    assign lineStart = (hCount == '0) && (slot == '0);

    assign beam.slot     = slot;
    assign beam.hCount   = hCount;
    assign beam.vCount   = vCount;
    assign beam.firqTrig = lineStart && !vCount[0];     // Even lines
    assign beam.nmiTrig  = lineStart &&
        ((vCount % tileLayerPkg::vCountT'(`TL_NMI_LINES)) == '0);
    assign beam.irqTrig  = lineStart &&
        (vCount == tileLayerPkg::vCountT'(`TL_VBLANK_LINE));  // Blanking entry

endmodule

/* verilog/tileLayerIf.sv */
// Beam and CPU VRAM interfaces linking timing, register and sequencer blocks
`timescale 1ns/10ps
`include "tileLayerGen_settings.svh"

//--------------------------------------------------------------------------
// Beam position and event pulses
//--------------------------------------------------------------------------
interface beamIf;
    tileLayerPkg::slotT   slot;     // Current VRAM slot
    tileLayerPkg::hCountT hCount;   // Beam pixel
    tileLayerPkg::vCountT vCount;   // Beam line
    logic                 irqTrig;  // Blanking start
    logic                 firqTrig; // Even line start
    logic                 nmiTrig;  // Every NMI period

    modport timing (output slot, hCount, vCount, irqTrig, firqTrig, nmiTrig);
    modport seq    (input  slot, hCount, vCount);
    modport regs   (input  irqTrig, firqTrig, nmiTrig);
endinterface

//--------------------------------------------------------------------------
// CPU request into the VRAM slot
//--------------------------------------------------------------------------
interface cpuVramIf;
    logic                  req;     // Access pending
    logic                  write;   // Write when set
    logic [`TL_ADDR_W-1:0] addr;    // VRAM address
    logic [7:0]            wdata;   // Write data
    logic                  grant;   // Slot taken, access done
    logic [7:0]            rdata;   // Read data during grant

    modport regs (
        output req, write, addr, wdata,
        input  grant, rdata
    );
    modport seq (
        input  req, write, addr, wdata,
        output grant, rdata
    );
endinterface

/* verilog/tileLayerPkg.sv */
// Tile layer generator types for beam counters, slots, VRAM addresses and interrupts
package tileLayerPkg;

    typedef logic [8:0] hCountT;    // Pixel within line
    typedef logic [8:0] vCountT;    // Line within frame
    typedef logic [1:0] slotT;      // VRAM slot within pixel

    // Tilemap fetch address
    typedef struct packed {
        logic [1:0] layer;          // Layer select
        logic [4:0] row;            // Tile row
        logic [5:0] column;         // Tile column
    } mapAddrT;

    // Scroll RAM fetch address
    typedef struct packed {
        logic [3:0] page;           // Fixed scroll page
        logic       spare;          // Unused, kept zero
        logic [7:0] line;           // Beam line
    } scrollAddrT;

    // One VRAM address word, seen as map or scroll address
    typedef union packed {
        mapAddrT    map;
        scrollAddrT scroll;
    } vramAddrU;

    // Interrupt bits, nmi in bit 0
    typedef struct packed {
        logic irq;
        logic firq;
        logic nmi;
    } intVecT;

endpackage

/* verilog/tileLayerGen_settings.svh */
// Tile layer generator settings for beam totals, event lines, VRAM slots and register map
`ifndef TILE_LAYER_GEN_SETTINGS_SVH
`define TILE_LAYER_GEN_SETTINGS_SVH

//--------------------------------------------------------------------------
// Beam geometry
//--------------------------------------------------------------------------
`define TL_H_TOTAL      384         // Pixels per line
`define TL_V_TOTAL      264         // Lines per frame
`define TL_VBLANK_LINE  240         // First line of vertical blanking
`define TL_NMI_LINES    16          // NMI period in lines

//--------------------------------------------------------------------------
// VRAM slots and address map
//--------------------------------------------------------------------------
`define TL_ADDR_W       13          // VRAM address bits
`define TL_SLOT_MAP_A   2'd0        // Layer A map fetch
`define TL_SLOT_MAP_B   2'd1        // Layer B map fetch
`define TL_SLOT_CPU     2'd2        // CPU access
`define TL_SLOT_SCROLL  2'd3        // Scroll RAM fetch
`define TL_SCROLL_PAGE  4'b1101     // Scroll RAM page, address bits 12..9

// Register window decode
`define TL_REG_WINDOW   13'h1C00    // Bits 12..10 all set
`define TL_REG_INT      13'h1D00    // Interrupt enables
`define TL_REG_FLIP     13'h1E80    // Flip screen

`endif
